//--- riscv_em_pkg.sv
`default_nettype none

package riscv_em_pkg;

    localparam int XLEN       = 64;
    localparam int REGADDR_W  = 5;
    localparam int BYTE_LANES = XLEN / 8;
    localparam int OFF_W      = 3;             // byte offset inside a doubleword
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;             // index from address bits 8..3

    // major opcodes in RISC-V encoding
    typedef enum logic [6:0] {
        OPC_NONE  = 7'b0000000,                // bubble
        OPC_LOAD  = 7'b0000011,
        OPC_OPIMM = 7'b0010011,
        OPC_STORE = 7'b0100011,
        OPC_OP    = 7'b0110011,
        OPC_LUI   = 7'b0110111,
        OPC_JALR  = 7'b1100111,
        OPC_JAL   = 7'b1101111
    } opcode_e;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11
    } resultsrc_e;

    // store size
    typedef enum logic [1:0] {
        ST_B = 2'b00,
        ST_H = 2'b01,
        ST_W = 2'b10,
        ST_D = 2'b11
    } storesrc_e;

    // load size and extension
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_D  = 3'b011,
        LD_BU = 3'b100,
        LD_HU = 3'b101,
        LD_WU = 3'b110
    } memext_e;

endpackage

`default_nettype wire

//--- riscv_em_ppreg.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_em_ppreg
    import riscv_em_pkg::*;
(
    input  logic                 i_riscv_em_clk,
    input  logic                 i_riscv_em_rst,
    input  logic                 i_riscv_em_en,         // high = stall
    input  logic                 i_riscv_em_flush,
    input  logic                 i_riscv_em_regw_e,
    input  logic [1:0]           i_riscv_em_resultsrc_e,
    input  logic [1:0]           i_riscv_em_storesrc_e,
    input  logic [2:0]           i_riscv_em_memext_e,
    input  logic [XLEN-1:0]      i_riscv_em_pcplus4_e,
    input  logic [XLEN-1:0]      i_riscv_em_result_e,
    input  logic [XLEN-1:0]      i_riscv_em_storedata_e,
    input  logic [REGADDR_W-1:0] i_riscv_em_rdaddr_e,
    input  logic [XLEN-1:0]      i_riscv_em_imm_e,
    input  logic [6:0]           i_riscv_em_opcode_e,
    output logic                 o_riscv_em_regw_m,
    output resultsrc_e           o_riscv_em_resultsrc_m,
    output storesrc_e            o_riscv_em_storesrc_m,
    output memext_e              o_riscv_em_memext_m,
    output logic [XLEN-1:0]      o_riscv_em_pcplus4_m,
    output logic [XLEN-1:0]      o_riscv_em_result_m,
    output logic [XLEN-1:0]      o_riscv_em_storedata_m,
    output logic [REGADDR_W-1:0] o_riscv_em_rdaddr_m,
    output logic [XLEN-1:0]      o_riscv_em_imm_m,
    output opcode_e              o_riscv_em_opcode_m
);

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : em_preg_proc
        if (i_riscv_em_rst)
        begin
            o_riscv_em_regw_m      <= 1'b0;
            o_riscv_em_resultsrc_m <= RES_ALU;
            o_riscv_em_storesrc_m  <= ST_B;
            o_riscv_em_memext_m    <= LD_B;
            o_riscv_em_pcplus4_m   <= '0;
            o_riscv_em_result_m    <= '0;
            o_riscv_em_storedata_m <= '0;
            o_riscv_em_rdaddr_m    <= '0;
            o_riscv_em_imm_m       <= '0;
            o_riscv_em_opcode_m    <= OPC_NONE;
        end
        else if (i_riscv_em_flush)
        begin
            // flush bubble wins over stall
            o_riscv_em_regw_m      <= 1'b0;
            o_riscv_em_resultsrc_m <= RES_ALU;
            o_riscv_em_storesrc_m  <= ST_B;
            o_riscv_em_memext_m    <= LD_B;
            o_riscv_em_pcplus4_m   <= '0;
            o_riscv_em_result_m    <= '0;
            o_riscv_em_storedata_m <= '0;
            o_riscv_em_rdaddr_m    <= '0;
            o_riscv_em_imm_m       <= '0;
            o_riscv_em_opcode_m    <= OPC_NONE;
        end
        else if (!i_riscv_em_en)
        begin
            o_riscv_em_regw_m      <= i_riscv_em_regw_e;
            o_riscv_em_resultsrc_m <= resultsrc_e'(i_riscv_em_resultsrc_e);
            o_riscv_em_storesrc_m  <= storesrc_e'(i_riscv_em_storesrc_e);
            o_riscv_em_memext_m    <= memext_e'(i_riscv_em_memext_e);
            o_riscv_em_pcplus4_m   <= i_riscv_em_pcplus4_e;
            o_riscv_em_result_m    <= i_riscv_em_result_e;
            o_riscv_em_storedata_m <= i_riscv_em_storedata_e;
            o_riscv_em_rdaddr_m    <= i_riscv_em_rdaddr_e;
            o_riscv_em_imm_m       <= i_riscv_em_imm_e;
            o_riscv_em_opcode_m    <= opcode_e'(i_riscv_em_opcode_e);
        end
    end

endmodule

`default_nettype wire

//--- riscv_em_memstage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_em_memstage
    import riscv_em_pkg::*;
(
    input  opcode_e                i_riscv_em_opcode_m,
    input  storesrc_e              i_riscv_em_storesrc_m,
    input  memext_e                i_riscv_em_memext_m,
    input  logic [XLEN-1:0]        i_riscv_em_result_m,     // address
    input  logic [XLEN-1:0]        i_riscv_em_storedata_m,
    input  logic [XLEN-1:0]        i_riscv_em_rdata,
    output logic [DMEM_AW-1:0]     o_riscv_em_dmem_idx,
    output logic [XLEN-1:0]        o_riscv_em_dmem_wdata,
    output logic [BYTE_LANES-1:0]  o_riscv_em_dmem_be,
    output logic                   o_riscv_em_dmem_we,
    output logic [XLEN-1:0]        o_riscv_em_loadval_m,
    output logic                   o_riscv_em_load_addr_misaligned_m,
    output logic                   o_riscv_em_store_addr_misaligned_m
);

    logic [OFF_W-1:0] off;
    logic             is_load;
    logic             is_store;
    logic             ld_mis;
    logic             st_mis;
    logic [XLEN-1:0]  lane;
    logic [XLEN-1:0]  ext;

    assign off      = i_riscv_em_result_m[OFF_W-1:0];
    assign is_load  = (i_riscv_em_opcode_m == OPC_LOAD);
    assign is_store = (i_riscv_em_opcode_m == OPC_STORE);

    assign o_riscv_em_dmem_idx = i_riscv_em_result_m[DMEM_AW+OFF_W-1:OFF_W];

    always_comb
    begin
        case (i_riscv_em_memext_m)
            LD_B, LD_BU: ld_mis = 1'b0;
            LD_H, LD_HU: ld_mis = off[0];
            LD_W, LD_WU: ld_mis = |off[1:0];
            default:     ld_mis = |off;
        endcase
        case (i_riscv_em_storesrc_m)
            ST_B:    st_mis = 1'b0;
            ST_H:    st_mis = off[0];
            ST_W:    st_mis = |off[1:0];
            default: st_mis = |off;
        endcase
        case (i_riscv_em_storesrc_m)
            ST_B:    o_riscv_em_dmem_be = 8'b0000_0001 << off;
            ST_H:    o_riscv_em_dmem_be = 8'b0000_0011 << off;
            ST_W:    o_riscv_em_dmem_be = 8'b0000_1111 << off;
            default: o_riscv_em_dmem_be = 8'b1111_1111;
        endcase
    end

    // replicate store data so every lane carries it
    always_comb
    begin
        case (i_riscv_em_storesrc_m)
            ST_B:    o_riscv_em_dmem_wdata = {8{i_riscv_em_storedata_m[7:0]}};
            ST_H:    o_riscv_em_dmem_wdata = {4{i_riscv_em_storedata_m[15:0]}};
            ST_W:    o_riscv_em_dmem_wdata = {2{i_riscv_em_storedata_m[31:0]}};
            default: o_riscv_em_dmem_wdata = i_riscv_em_storedata_m;
        endcase
    end

    assign o_riscv_em_load_addr_misaligned_m  = is_load & ld_mis;
    assign o_riscv_em_store_addr_misaligned_m = is_store & st_mis;
    assign o_riscv_em_dmem_we                 = is_store & ~st_mis;

    assign lane = i_riscv_em_rdata >> {off, 3'b000};   // addressed byte to bit 0

    always_comb
    begin
        case (i_riscv_em_memext_m)
            LD_B:    ext = {{(XLEN-8){lane[7]}}, lane[7:0]};
            LD_H:    ext = {{(XLEN-16){lane[15]}}, lane[15:0]};
            LD_W:    ext = {{(XLEN-32){lane[31]}}, lane[31:0]};
            LD_BU:   ext = {{(XLEN-8){1'b0}}, lane[7:0]};
            LD_HU:   ext = {{(XLEN-16){1'b0}}, lane[15:0]};
            LD_WU:   ext = {{(XLEN-32){1'b0}}, lane[31:0]};
            default: ext = lane;
        endcase
    end

    assign o_riscv_em_loadval_m = (is_load && !ld_mis) ? ext : '0;

endmodule

`default_nettype wire

//--- riscv_em_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_em_dmem
    import riscv_em_pkg::*;
(
    input  logic                  i_riscv_em_clk,
    input  logic                  i_riscv_em_rst,
    input  logic [DMEM_AW-1:0]    i_riscv_em_idx,
    input  logic [XLEN-1:0]       i_riscv_em_wdata,
    input  logic [BYTE_LANES-1:0] i_riscv_em_be,
    input  logic                  i_riscv_em_we,
    output logic [XLEN-1:0]       o_riscv_em_rdata
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : dmem_write_proc
        if (i_riscv_em_rst)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_riscv_em_we)
        begin
            for (int b = 0; b < BYTE_LANES; b++)
            begin
                if (i_riscv_em_be[b])
                begin
                    mem[i_riscv_em_idx][b*8 +: 8] <= i_riscv_em_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign o_riscv_em_rdata = mem[i_riscv_em_idx];   // async read

endmodule

`default_nettype wire

//--- riscv_em_wbstage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_em_wbstage
    import riscv_em_pkg::*;
(
    input  logic                 i_riscv_em_clk,
    input  logic                 i_riscv_em_rst,
    input  logic                 i_riscv_em_en,          // high = stall
    input  logic                 i_riscv_em_regw_m,
    input  resultsrc_e           i_riscv_em_resultsrc_m,
    input  logic [REGADDR_W-1:0] i_riscv_em_rdaddr_m,
    input  logic [XLEN-1:0]      i_riscv_em_result_m,
    input  logic [XLEN-1:0]      i_riscv_em_loadval_m,
    input  logic [XLEN-1:0]      i_riscv_em_pcplus4_m,
    input  logic [XLEN-1:0]      i_riscv_em_imm_m,
    input  logic                 i_riscv_em_load_addr_misaligned_m,
    input  logic                 i_riscv_em_store_addr_misaligned_m,
    output logic                 o_riscv_em_regw_w,
    output logic [REGADDR_W-1:0] o_riscv_em_rdaddr_w,
    output logic [XLEN-1:0]      o_riscv_em_wbdata_w,
    output logic                 o_riscv_em_load_addr_misaligned_w,
    output logic                 o_riscv_em_store_addr_misaligned_w
);

    logic [XLEN-1:0] wbdata_sel;

    always_comb
    begin
        case (i_riscv_em_resultsrc_m)
            RES_MEM: wbdata_sel = i_riscv_em_loadval_m;
            RES_PC4: wbdata_sel = i_riscv_em_pcplus4_m;
            RES_IMM: wbdata_sel = i_riscv_em_imm_m;
            default: wbdata_sel = i_riscv_em_result_m;
        endcase
    end

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : mw_preg_proc
        if (i_riscv_em_rst)
        begin
            o_riscv_em_regw_w                  <= 1'b0;
            o_riscv_em_rdaddr_w                <= '0;
            o_riscv_em_wbdata_w                <= '0;
            o_riscv_em_load_addr_misaligned_w  <= 1'b0;
            o_riscv_em_store_addr_misaligned_w <= 1'b0;
        end
        else if (!i_riscv_em_en)
        begin
            // no register write for a faulting load
            o_riscv_em_regw_w                  <= i_riscv_em_regw_m &
                                                  ~i_riscv_em_load_addr_misaligned_m;
            o_riscv_em_rdaddr_w                <= i_riscv_em_rdaddr_m;
            o_riscv_em_wbdata_w                <= wbdata_sel;
            o_riscv_em_load_addr_misaligned_w  <= i_riscv_em_load_addr_misaligned_m;
            o_riscv_em_store_addr_misaligned_w <= i_riscv_em_store_addr_misaligned_m;
        end
    end

endmodule

`default_nettype wire

//--- riscv_em_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_em_top
    import riscv_em_pkg::*;
(
    input  logic                 i_riscv_em_clk,
    input  logic                 i_riscv_em_rst,
    input  logic                 i_riscv_em_en,
    input  logic                 i_riscv_em_flush,
    input  logic                 i_riscv_em_regw_e,
    input  logic [1:0]           i_riscv_em_resultsrc_e,
    input  logic [1:0]           i_riscv_em_storesrc_e,
    input  logic [2:0]           i_riscv_em_memext_e,
    input  logic [XLEN-1:0]      i_riscv_em_pcplus4_e,
    input  logic [XLEN-1:0]      i_riscv_em_result_e,
    input  logic [XLEN-1:0]      i_riscv_em_storedata_e,
    input  logic [REGADDR_W-1:0] i_riscv_em_rdaddr_e,
    input  logic [XLEN-1:0]      i_riscv_em_imm_e,
    input  logic [6:0]           i_riscv_em_opcode_e,
    output logic                 o_riscv_em_regw_w,
    output logic [REGADDR_W-1:0] o_riscv_em_rdaddr_w,
    output logic [XLEN-1:0]      o_riscv_em_wbdata_w,
    output logic                 o_riscv_em_load_addr_misaligned_w,
    output logic                 o_riscv_em_store_addr_misaligned_w
);

    logic                  regw_m;
    resultsrc_e            resultsrc_m;
    storesrc_e             storesrc_m;
    memext_e               memext_m;
    logic [XLEN-1:0]       pcplus4_m;
    logic [XLEN-1:0]       result_m;
    logic [XLEN-1:0]       storedata_m;
    logic [REGADDR_W-1:0]  rdaddr_m;
    logic [XLEN-1:0]       imm_m;
    opcode_e               opcode_m;
    logic [DMEM_AW-1:0]    dmem_idx;
    logic [XLEN-1:0]       dmem_wdata;
    logic [BYTE_LANES-1:0] dmem_be;
    logic                  dmem_we;
    logic [XLEN-1:0]       dmem_rdata;
    logic [XLEN-1:0]       loadval_m;
    logic                  load_mis_m;
    logic                  store_mis_m;

    riscv_em_ppreg u_ppreg (
        .i_riscv_em_clk         (i_riscv_em_clk),
        .i_riscv_em_rst         (i_riscv_em_rst),
        .i_riscv_em_en          (i_riscv_em_en),
        .i_riscv_em_flush       (i_riscv_em_flush),
        .i_riscv_em_regw_e      (i_riscv_em_regw_e),
        .i_riscv_em_resultsrc_e (i_riscv_em_resultsrc_e),
        .i_riscv_em_storesrc_e  (i_riscv_em_storesrc_e),
        .i_riscv_em_memext_e    (i_riscv_em_memext_e),
        .i_riscv_em_pcplus4_e   (i_riscv_em_pcplus4_e),
        .i_riscv_em_result_e    (i_riscv_em_result_e),
        .i_riscv_em_storedata_e (i_riscv_em_storedata_e),
        .i_riscv_em_rdaddr_e    (i_riscv_em_rdaddr_e),
        .i_riscv_em_imm_e       (i_riscv_em_imm_e),
        .i_riscv_em_opcode_e    (i_riscv_em_opcode_e),
        .o_riscv_em_regw_m      (regw_m),
        .o_riscv_em_resultsrc_m (resultsrc_m),
        .o_riscv_em_storesrc_m  (storesrc_m),
        .o_riscv_em_memext_m    (memext_m),
        .o_riscv_em_pcplus4_m   (pcplus4_m),
        .o_riscv_em_result_m    (result_m),
        .o_riscv_em_storedata_m (storedata_m),
        .o_riscv_em_rdaddr_m    (rdaddr_m),
        .o_riscv_em_imm_m       (imm_m),
        .o_riscv_em_opcode_m    (opcode_m)
    );

    riscv_em_memstage u_memstage (
        .i_riscv_em_opcode_m                (opcode_m),
        .i_riscv_em_storesrc_m              (storesrc_m),
        .i_riscv_em_memext_m                (memext_m),
        .i_riscv_em_result_m                (result_m),
        .i_riscv_em_storedata_m             (storedata_m),
        .i_riscv_em_rdata                   (dmem_rdata),
        .o_riscv_em_dmem_idx                (dmem_idx),
        .o_riscv_em_dmem_wdata              (dmem_wdata),
        .o_riscv_em_dmem_be                 (dmem_be),
        .o_riscv_em_dmem_we                 (dmem_we),
        .o_riscv_em_loadval_m               (loadval_m),
        .o_riscv_em_load_addr_misaligned_m  (load_mis_m),
        .o_riscv_em_store_addr_misaligned_m (store_mis_m)
    );

    riscv_em_dmem u_dmem (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_idx   (dmem_idx),
        .i_riscv_em_wdata (dmem_wdata),
        .i_riscv_em_be    (dmem_be),
        .i_riscv_em_we    (dmem_we),
        .o_riscv_em_rdata (dmem_rdata)
    );

    riscv_em_wbstage u_wbstage (
        .i_riscv_em_clk                     (i_riscv_em_clk),
        .i_riscv_em_rst                     (i_riscv_em_rst),
        .i_riscv_em_en                      (i_riscv_em_en),
        .i_riscv_em_regw_m                  (regw_m),
        .i_riscv_em_resultsrc_m             (resultsrc_m),
        .i_riscv_em_rdaddr_m                (rdaddr_m),
        .i_riscv_em_result_m                (result_m),
        .i_riscv_em_loadval_m               (loadval_m),
        .i_riscv_em_pcplus4_m               (pcplus4_m),
        .i_riscv_em_imm_m                   (imm_m),
        .i_riscv_em_load_addr_misaligned_m  (load_mis_m),
        .i_riscv_em_store_addr_misaligned_m (store_mis_m),
        .o_riscv_em_regw_w                  (o_riscv_em_regw_w),
        .o_riscv_em_rdaddr_w                (o_riscv_em_rdaddr_w),
        .o_riscv_em_wbdata_w                (o_riscv_em_wbdata_w),
        .o_riscv_em_load_addr_misaligned_w  (o_riscv_em_load_addr_misaligned_w),
        .o_riscv_em_store_addr_misaligned_w (o_riscv_em_store_addr_misaligned_w)
    );

endmodule

`default_nettype wire

//--- tb_riscv_em_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_em_top
    import riscv_em_pkg::*;
();

    logic                 clk;
    logic                 rst;
    logic                 stall;
    logic                 flush;
    logic                 in_regw;
    logic [1:0]           in_res;
    logic [1:0]           in_st;
    logic [2:0]           in_ext;
    logic [XLEN-1:0]      in_pc4;
    logic [XLEN-1:0]      in_alu;
    logic [XLEN-1:0]      in_sd;
    logic [REGADDR_W-1:0] in_rd;
    logic [XLEN-1:0]      in_imm;
    logic [6:0]           in_opc;
    logic                 wb_regw;
    logic [REGADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]      wb_data;
    logic                 wb_lmis;
    logic                 wb_smis;

    logic [7:0]           mem_model [512];   // byte view of the data memory
    logic                 m_regw;
    logic [1:0]           m_res;
    logic [1:0]           m_st;
    logic [2:0]           m_ext;
    logic [XLEN-1:0]      m_pc4;
    logic [XLEN-1:0]      m_alu;
    logic [XLEN-1:0]      m_sd;
    logic [REGADDR_W-1:0] m_rd;
    logic [XLEN-1:0]      m_imm;
    logic [6:0]           m_opc;
    logic                 exp_regw;
    logic [REGADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]      exp_data;
    logic                 exp_lmis;
    logic                 exp_smis;
    integer               seed;
    int                   value_errs;
    int                   timeout_errs;

    riscv_em_top UUT (
        .i_riscv_em_clk                     (clk),
        .i_riscv_em_rst                     (rst),
        .i_riscv_em_en                      (stall),
        .i_riscv_em_flush                   (flush),
        .i_riscv_em_regw_e                  (in_regw),
        .i_riscv_em_resultsrc_e             (in_res),
        .i_riscv_em_storesrc_e              (in_st),
        .i_riscv_em_memext_e                (in_ext),
        .i_riscv_em_pcplus4_e               (in_pc4),
        .i_riscv_em_result_e                (in_alu),
        .i_riscv_em_storedata_e             (in_sd),
        .i_riscv_em_rdaddr_e                (in_rd),
        .i_riscv_em_imm_e                   (in_imm),
        .i_riscv_em_opcode_e                (in_opc),
        .o_riscv_em_regw_w                  (wb_regw),
        .o_riscv_em_rdaddr_w                (wb_rd),
        .o_riscv_em_wbdata_w                (wb_data),
        .o_riscv_em_load_addr_misaligned_w  (wb_lmis),
        .o_riscv_em_store_addr_misaligned_w (wb_smis)
    );

    always #10 clk = ~clk;

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int load_size(input logic [2:0] ext);
        case (ext)
            LD_B, LD_BU: return 1;
            LD_H, LD_HU: return 2;
            LD_W, LD_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_load(input logic [8:0] a, input logic [2:0] ext);
        logic [XLEN-1:0] v;
        int              sz;
        sz = load_size(ext);
        v  = '0;
        for (int i = 0; i < sz; i++)
            v[i*8 +: 8] = mem_model[a + i];   // little endian
        if (ext inside {LD_B, LD_H, LD_W} && v[sz*8-1])
            v = v | ~((64'd1 << (sz * 8)) - 64'd1);
        return v;
    endfunction

    task automatic clear_m();
        {m_regw, m_res, m_st, m_ext, m_pc4, m_alu, m_sd, m_rd, m_imm, m_opc} = '0;
    endtask

    // one clock edge of the reference pipeline as seen at the next falling edge
    task automatic advance_model();
        logic lmis;
        logic smis;
        lmis = (m_opc == OPC_LOAD) && ((int'(m_alu[2:0]) % load_size(m_ext)) != 0);
        smis = (m_opc == OPC_STORE) && ((int'(m_alu[2:0]) % (1 << m_st)) != 0);
        if (rst)
        begin
            for (int i = 0; i < 512; i++)
                mem_model[i] = 8'h00;
            {exp_regw, exp_rd, exp_data, exp_lmis, exp_smis} = '0;
            clear_m();
        end
        else
        begin
            if (!stall)
            begin
                exp_regw = m_regw & ~lmis;
                exp_rd   = m_rd;
                exp_lmis = lmis;
                exp_smis = smis;
                case (m_res)
                    RES_MEM: exp_data = (m_opc == OPC_LOAD && !lmis) ?
                                        model_load(m_alu[8:0], m_ext) : '0;
                    RES_PC4: exp_data = m_pc4;
                    RES_IMM: exp_data = m_imm;
                    default: exp_data = m_alu;
                endcase
            end
            if (m_opc == OPC_STORE && !smis)
                for (int i = 0; i < (1 << m_st); i++)
                    mem_model[m_alu[8:0] + i] = m_sd[i*8 +: 8];
            if (flush)
                clear_m();
            else if (!stall)
                {m_regw, m_res, m_st, m_ext, m_pc4, m_alu, m_sd, m_rd, m_imm, m_opc} =
                    {in_regw, in_res, in_st, in_ext, in_pc4, in_alu, in_sd, in_rd, in_imm, in_opc};
        end
    endtask

    task automatic check_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp)
        else
        begin
            value_errs++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic tick();
        @(negedge clk);
        advance_model();
        check_field("regw_w", XLEN'(wb_regw), XLEN'(exp_regw));
        check_field("rdaddr_w", XLEN'(wb_rd), XLEN'(exp_rd));
        check_field("wbdata_w", wb_data, exp_data);
        check_field("load_misaligned_w", XLEN'(wb_lmis), XLEN'(exp_lmis));
        check_field("store_misaligned_w", XLEN'(wb_smis), XLEN'(exp_smis));
    endtask

    task automatic issue(input logic [6:0] opc, input logic regw, input logic [1:0] res,
                         input logic [1:0] st, input logic [2:0] ext,
                         input logic [XLEN-1:0] alu, input logic [XLEN-1:0] sd,
                         input logic [REGADDR_W-1:0] rd);
        in_opc  = opc;
        in_regw = regw;
        in_res  = res;
        in_st   = st;
        in_ext  = ext;
        in_alu  = alu;
        in_sd   = sd;
        in_rd   = rd;
        in_imm  = rand64();
        in_pc4  = rand64();
        tick();
    endtask

    task automatic idle();
        issue(OPC_NONE, 1'b0, RES_ALU, ST_B, LD_B, '0, '0, '0);
    endtask

    task automatic store_at(input logic [8:0] a, input logic [1:0] st, input logic [XLEN-1:0] d);
        issue(OPC_STORE, 1'b0, RES_ALU, st, LD_D, XLEN'(a), d, '0);
    endtask

    task automatic load_from(input logic [8:0] a, input logic [2:0] ext,
                             input logic [REGADDR_W-1:0] rd);
        issue(OPC_LOAD, 1'b1, RES_MEM, ST_B, ext, XLEN'(a), '0, rd);
    endtask

    task automatic wait_for_write(input logic [REGADDR_W-1:0] rd, input int limit);
        int n;
        n = 0;
        while (!(wb_regw && wb_rd == rd) && n < limit)
        begin
            idle();
            n++;
        end
        if (!(wb_regw && wb_rd == rd))
        begin
            timeout_errs++;
            $display("timeout: no register write to x%0d within %0d cycles", rd, limit);
        end
    endtask

    initial
    begin
        logic [8:0]      base;
        logic [XLEN-1:0] pick;
        logic [XLEN-1:0] snap_data;
        logic            snap_regw;
        int              off;
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        {in_regw, in_res, in_st, in_ext, in_pc4, in_alu, in_sd, in_rd, in_imm, in_opc} = '0;
        seed         = 32'he55165d5;
        value_errs   = 0;
        timeout_errs = 0;
        repeat (16) tick();                   // outputs stay zero in reset
        rst = 1'b0;
        idle();

        for (int r = 0; r < 8; r++)
        begin
            base = 9'(rand64()) & 9'h1f8;
            pick = rand64();
            store_at(base, ST_D, rand64());
            store_at(base | {6'd0, pick[0], 2'b00}, ST_W, rand64());
            store_at(base | {6'd0, pick[2:1], 1'b0}, ST_H, rand64());
            store_at(base | {6'd0, pick[5:3]}, ST_B, rand64());
            for (int e = 0; e < 7; e++)
            begin
                pick = rand64();
                off  = int'(pick[2:0]) & ~(load_size(3'(e)) - 1);
                load_from(base | 9'(off), 3'(e), 5'(e + 1));
            end
        end

        issue(OPC_OP, 1'b1, RES_ALU, ST_B, LD_B, rand64(), '0, 5'd1);
        issue(OPC_JAL, 1'b1, RES_PC4, ST_B, LD_B, rand64(), '0, 5'd2);
        issue(OPC_LUI, 1'b1, RES_IMM, ST_B, LD_B, rand64(), '0, 5'd3);
        issue(OPC_OPIMM, 1'b1, RES_ALU, ST_B, LD_B, rand64(), '0, 5'd4);
        issue(OPC_JALR, 1'b1, RES_PC4, ST_B, LD_B, rand64(), '0, 5'd5);

        store_at(9'h080, ST_D, rand64());
        flush = 1'b1;                         // both get dropped
        store_at(9'h080, ST_D, rand64());
        issue(OPC_OP, 1'b1, RES_ALU, ST_B, LD_B, rand64(), '0, 5'd6);
        flush = 1'b0;
        load_from(9'h080, LD_D, 5'd9);
        idle();
        idle();

        issue(OPC_OP, 1'b1, RES_ALU, ST_B, LD_B, 64'h0123_4567_89ab_cdef, '0, 5'd7);
        stall     = 1'b1;
        snap_data = wb_data;
        snap_regw = wb_regw;
        repeat (3)
        begin
            issue(OPC_LUI, 1'b1, RES_IMM, ST_B, LD_B, '0, '0, 5'd8);
            check_field("held wbdata_w", wb_data, snap_data);
            check_field("held regw_w", XLEN'(wb_regw), XLEN'(snap_regw));
        end
        stall = 1'b0;
        wait_for_write(5'd7, 4);
        repeat (3)
        begin
            idle();
            check_field("second write to x7", XLEN'(wb_regw && wb_rd == 5'd7), '0);
        end

        store_at(9'h100, ST_D, rand64());
        store_at(9'h101, ST_H, rand64());     // odd address so no write
        load_from(9'h100, LD_D, 5'd10);
        load_from(9'h102, LD_W, 5'd11);
        idle();
        idle();

        $display("errors: value %0d, timeout %0d", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
riscv_em_pkg.sv
riscv_em_ppreg.sv
riscv_em_memstage.sv
riscv_em_dmem.sv
riscv_em_wbstage.sv
riscv_em_top.sv
tb_riscv_em_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_em_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "simulation ended early, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
